/* common/fpu_pkg.sv */
package fpu_pkg;

	// register file geometry
	localparam int unsigned REG_NUM    = 32;
	localparam int unsigned REG_ADDR_W = 5;
	localparam int unsigned WORD_W     = 32;

	// exception interface
	localparam int unsigned EXC_CODE_W = 5;

	// exception code raised by the FPU
	localparam logic [EXC_CODE_W-1:0] EXCCODE_FPE = 5'd15;

	// how the bits of a register were last produced
	typedef enum logic [1:0] {
		FMT_UNKNOWN   = 2'd0,
		FMT_SINGLE    = 2'd1,
		FMT_WORD      = 2'd2,
		FMT_LONG_HALF = 2'd3
	} fpu_fmt_t;

	// cause vector, high to low:
	// unimplemented, invalid, divide-by-zero, overflow, underflow, inexact
	typedef logic [5:0] fpu_cause_t;

	// field view of the FCSR
	typedef struct packed {
		// condition bits 31:25 and fs bit 24
		logic [7:0]  fcc_fs;
		logic [5:0]  reserved;
		fpu_cause_t  cause;
		// no unimplemented bit in enables or flags
		logic [4:0]  enables;
		logic [4:0]  flags;
		logic [1:0]  rmode;
	} fcsr_fields_t;

	// software moves the raw word, the unit decodes the fields
	typedef union packed {
		logic [WORD_W-1:0] raw;
		fcsr_fields_t      f;
	} fcsr_word_u;

	// after reset only the top enable bit is set
	localparam logic [WORD_W-1:0] FCSR_RESET = 32'h0000_0800;

endpackage

/* fpu_regs/fpu_regfile.sv */
module fpu_regfile (
	input  logic                            clk,
	input  logic                            rst,

	// write port 1
	input  logic                            wr1_we,
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  wr1_addr,
	input  logic [fpu_pkg::WORD_W-1:0]      wr1_val,
	input  fpu_pkg::fpu_fmt_t               wr1_fmt,

	// write port 2, wins over port 1
	input  logic                            wr2_we,
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  wr2_addr,
	input  logic [fpu_pkg::WORD_W-1:0]      wr2_val,
	input  fpu_pkg::fpu_fmt_t               wr2_fmt,

	// read port 1
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  raddr1,
	output logic [fpu_pkg::WORD_W-1:0]      rval1,
	output fpu_pkg::fpu_fmt_t               rfmt1,

	// read port 2
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  raddr2,
	output logic [fpu_pkg::WORD_W-1:0]      rval2,
	output fpu_pkg::fpu_fmt_t               rfmt2,

	// read port 3
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  raddr3,
	output logic [fpu_pkg::WORD_W-1:0]      rval3,
	output fpu_pkg::fpu_fmt_t               rfmt3,

	// read port 4
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  raddr4,
	output logic [fpu_pkg::WORD_W-1:0]      rval4,
	output fpu_pkg::fpu_fmt_t               rfmt4
);
	import fpu_pkg::*;

	// architectural storage, value and format tag per entry
	logic [WORD_W-1:0] reg_val [REG_NUM];
	fpu_fmt_t          reg_fmt [REG_NUM];

	// read ports gathered so one mux body serves all four
	logic [REG_ADDR_W-1:0] raddr [4];
	logic [WORD_W-1:0]     rval  [4];
	fpu_fmt_t              rfmt  [4];

	assign raddr[0] = raddr1;
	assign raddr[1] = raddr2;
	assign raddr[2] = raddr3;
	assign raddr[3] = raddr4;

	assign rval1 = rval[0];
	assign rval2 = rval[1];
	assign rval3 = rval[2];
	assign rval4 = rval[3];

	assign rfmt1 = rfmt[0];
	assign rfmt2 = rfmt[1];
	assign rfmt3 = rfmt[2];
	assign rfmt4 = rfmt[3];

	// each entry picks port 2 first, then port 1
	always_ff @(posedge clk) begin
		for (int i = 0; i < REG_NUM; i++) begin
			if (rst) begin
				reg_val[i] <= '0;
				reg_fmt[i] <= FMT_UNKNOWN;
			end else if (wr2_we && wr2_addr == REG_ADDR_W'(i)) begin
				reg_val[i] <= wr2_val;
				reg_fmt[i] <= wr2_fmt;
			end else if (wr1_we && wr1_addr == REG_ADDR_W'(i)) begin
				reg_val[i] <= wr1_val;
				reg_fmt[i] <= wr1_fmt;
			end
		end
	end

	// combinational reads with same-cycle write bypass
	genvar p;
	for (p = 0; p < 4; p++) begin : g_rd
		always_comb begin
			if (rst) begin
				rval[p] = '0;
				rfmt[p] = FMT_UNKNOWN;
			end else if (wr2_we && raddr[p] == wr2_addr) begin
				rval[p] = wr2_val;
				rfmt[p] = wr2_fmt;
			end else if (wr1_we && raddr[p] == wr1_addr) begin
				rval[p] = wr1_val;
				rfmt[p] = wr1_fmt;
			end else begin
				// no write in flight to this address
				rval[p] = reg_val[raddr[p]];
				rfmt[p] = reg_fmt[raddr[p]];
			end
		end
	end

endmodule

/* fpu_regs/fpu_csr.sv */
module fpu_csr (
	input  logic                            clk,
	input  logic                            rst,

	// software access
	input  logic                            fcsr_we,
	input  fpu_pkg::fcsr_word_u             fcsr_wdata,
	output fpu_pkg::fcsr_word_u             fcsr,

	// exception flush from the pipeline
	input  logic                            except_flush,
	input  logic [fpu_pkg::EXC_CODE_W-1:0]  except_code,
	input  fpu_pkg::fpu_cause_t             except_extra
);
	import fpu_pkg::*;

	// value held between cycles
	logic [WORD_W-1:0] fcsr_q;

	// flush that carries a floating-point cause
	logic fpe_flush;

	assign fpe_flush = except_flush && (except_code == EXCCODE_FPE);

	// next FCSR word, also the visible value
	always_comb begin
		if (rst) begin
			fcsr.raw = FCSR_RESET;
		end else if (fcsr_we) begin
			fcsr.raw = fcsr_wdata.raw;
		end else begin
			fcsr.raw = fcsr_q;
		end

		// cause overlay, everything else untouched
		if (fpe_flush) begin
			fcsr.f.cause = except_extra;
		end
	end

	// capture whatever is shown, reset value included
	always_ff @(posedge clk) begin
		fcsr_q <= fcsr.raw;
	end

endmodule

/* hdl/fpu_state.sv */
module fpu_state (
	input  logic                            clk,
	input  logic                            rst,

	// register write port 1
	input  logic                            wr1_we,
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  wr1_addr,
	input  logic [fpu_pkg::WORD_W-1:0]      wr1_val,
	input  fpu_pkg::fpu_fmt_t               wr1_fmt,

	// register write port 2
	input  logic                            wr2_we,
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  wr2_addr,
	input  logic [fpu_pkg::WORD_W-1:0]      wr2_val,
	input  fpu_pkg::fpu_fmt_t               wr2_fmt,

	// register read ports
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  raddr1,
	output logic [fpu_pkg::WORD_W-1:0]      rval1,
	output fpu_pkg::fpu_fmt_t               rfmt1,
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  raddr2,
	output logic [fpu_pkg::WORD_W-1:0]      rval2,
	output fpu_pkg::fpu_fmt_t               rfmt2,
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  raddr3,
	output logic [fpu_pkg::WORD_W-1:0]      rval3,
	output fpu_pkg::fpu_fmt_t               rfmt3,
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  raddr4,
	output logic [fpu_pkg::WORD_W-1:0]      rval4,
	output fpu_pkg::fpu_fmt_t               rfmt4,

	// FCSR as a raw word
	input  logic                            fcsr_we,
	input  logic [fpu_pkg::WORD_W-1:0]      fcsr_wdata,
	output logic [fpu_pkg::WORD_W-1:0]      fcsr,

	// exception flush
	input  logic                            except_flush,
	input  logic [fpu_pkg::EXC_CODE_W-1:0]  except_code,
	input  fpu_pkg::fpu_cause_t             except_extra
);

	// floating-point registers
	fpu_regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.wr1_we   (wr1_we),
		.wr1_addr (wr1_addr),
		.wr1_val  (wr1_val),
		.wr1_fmt  (wr1_fmt),
		.wr2_we   (wr2_we),
		.wr2_addr (wr2_addr),
		.wr2_val  (wr2_val),
		.wr2_fmt  (wr2_fmt),
		.raddr1   (raddr1),
		.rval1    (rval1),
		.rfmt1    (rfmt1),
		.raddr2   (raddr2),
		.rval2    (rval2),
		.rfmt2    (rfmt2),
		.raddr3   (raddr3),
		.rval3    (rval3),
		.rfmt3    (rfmt3),
		.raddr4   (raddr4),
		.rval4    (rval4),
		.rfmt4    (rfmt4)
	);

	// control/status register, raw words map onto the union ports
	fpu_csr u_csr (
		.clk          (clk),
		.rst          (rst),
		.fcsr_we      (fcsr_we),
		.fcsr_wdata   (fcsr_wdata),
		.fcsr         (fcsr),
		.except_flush (except_flush),
		.except_code  (except_code),
		.except_extra (except_extra)
	);

endmodule

/* verif/fpu_state_checker.sv */
module fpu_state_checker (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            wr1_we,
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  wr1_addr,
	input  logic                            wr2_we,
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  wr2_addr,
	input  logic [fpu_pkg::WORD_W-1:0]      wr2_val,
	input  logic [fpu_pkg::REG_ADDR_W-1:0]  raddr1,
	input  logic [fpu_pkg::WORD_W-1:0]      rval1,
	input  logic [fpu_pkg::WORD_W-1:0]      rval2,
	input  logic [fpu_pkg::WORD_W-1:0]      rval3,
	input  logic [fpu_pkg::WORD_W-1:0]      rval4,
	input  fpu_pkg::fpu_fmt_t               rfmt1,
	input  fpu_pkg::fpu_fmt_t               rfmt2,
	input  fpu_pkg::fpu_fmt_t               rfmt3,
	input  fpu_pkg::fpu_fmt_t               rfmt4,
	input  logic                            fcsr_we,
	input  logic [fpu_pkg::WORD_W-1:0]      fcsr,
	input  logic                            except_flush,
	input  logic [fpu_pkg::EXC_CODE_W-1:0]  except_code
);
	timeunit 1ns;
	timeprecision 100ps;
	import fpu_pkg::*;

	logic reads_cleared;
	logic dual_same;
	logic rd1_free;
	logic fpe_flush;

	assign reads_cleared = rval1 == '0 && rval2 == '0 && rval3 == '0 && rval4 == '0
		&& rfmt1 == FMT_UNKNOWN && rfmt2 == FMT_UNKNOWN
		&& rfmt3 == FMT_UNKNOWN && rfmt4 == FMT_UNKNOWN;

	// both write ports on one register
	assign dual_same = wr1_we && wr2_we && wr1_addr == wr2_addr;

	// read port 1 not hit by a bypass this cycle
	assign rd1_free = !(wr1_we && wr1_addr == raddr1) && !(wr2_we && wr2_addr == raddr1);

	assign fpe_flush = except_flush && except_code == EXCCODE_FPE;

	a_reset_reads: assert property (@(posedge clk) rst |-> reads_cleared)
		else $error("read ports not cleared while rst is high");

	a_dual_priority: assert property (@(posedge clk) disable iff (rst)
		dual_same |=> (raddr1 != $past(wr2_addr) || !rd1_free || rval1 == $past(wr2_val)))
		else $error("port 1 data stored over port 2 data");

	a_fcsr_hold: assert property (@(posedge clk) disable iff (rst)
		(!fcsr_we && !fpe_flush) |-> fcsr == $past(fcsr))
		else $error("fcsr changed without a write or FPE flush");

endmodule

bind fpu_state fpu_state_checker u_checker (
	.clk          (clk),
	.rst          (rst),
	.wr1_we       (wr1_we),
	.wr1_addr     (wr1_addr),
	.wr2_we       (wr2_we),
	.wr2_addr     (wr2_addr),
	.wr2_val      (wr2_val),
	.raddr1       (raddr1),
	.rval1        (rval1),
	.rval2        (rval2),
	.rval3        (rval3),
	.rval4        (rval4),
	.rfmt1        (rfmt1),
	.rfmt2        (rfmt2),
	.rfmt3        (rfmt3),
	.rfmt4        (rfmt4),
	.fcsr_we      (fcsr_we),
	.fcsr         (fcsr),
	.except_flush (except_flush),
	.except_code  (except_code)
);

/* verif/fpu_state_tb.sv */
module fpu_state_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import fpu_pkg::*;

	localparam int          RST_CYCLES  = 8;
	localparam int          RST_TIMEOUT = 20;
	localparam logic [31:0] LFSR_SEED   = 32'd4078;
	localparam string       TESTS_FILE  = "verif/fpu_state_tests.txt";

	logic clk;
	logic rst;

	logic                  wr1_we;
	logic [REG_ADDR_W-1:0] wr1_addr;
	logic [WORD_W-1:0]     wr1_val;
	fpu_fmt_t              wr1_fmt;
	logic                  wr2_we;
	logic [REG_ADDR_W-1:0] wr2_addr;
	logic [WORD_W-1:0]     wr2_val;
	fpu_fmt_t              wr2_fmt;

	// read ports indexed 1 to 4 like the DUT port names
	logic [REG_ADDR_W-1:0] raddr [1:4];
	logic [WORD_W-1:0]     rval  [1:4];
	fpu_fmt_t              rfmt  [1:4];

	logic                  fcsr_we;
	logic [WORD_W-1:0]     fcsr_wdata;
	logic [WORD_W-1:0]     fcsr;
	logic                  except_flush;
	logic [EXC_CODE_W-1:0] except_code;
	fpu_cause_t            except_extra;

	// expected register contents
	logic [WORD_W-1:0] model_val [REG_NUM];
	fpu_fmt_t          model_fmt [REG_NUM];

	logic [31:0] lfsr;
	int          error_count;
	int          pass_count;
	int          fail_count;
	bit          aborted;

	fpu_state uut (
		.clk          (clk),
		.rst          (rst),
		.wr1_we       (wr1_we),
		.wr1_addr     (wr1_addr),
		.wr1_val      (wr1_val),
		.wr1_fmt      (wr1_fmt),
		.wr2_we       (wr2_we),
		.wr2_addr     (wr2_addr),
		.wr2_val      (wr2_val),
		.wr2_fmt      (wr2_fmt),
		.raddr1       (raddr[1]),
		.rval1        (rval[1]),
		.rfmt1        (rfmt[1]),
		.raddr2       (raddr[2]),
		.rval2        (rval[2]),
		.rfmt2        (rfmt[2]),
		.raddr3       (raddr[3]),
		.rval3        (rval[3]),
		.rfmt3        (rfmt[3]),
		.raddr4       (raddr[4]),
		.rval4        (rval[4]),
		.rfmt4        (rfmt[4]),
		.fcsr_we      (fcsr_we),
		.fcsr_wdata   (fcsr_wdata),
		.fcsr         (fcsr),
		.except_flush (except_flush),
		.except_code  (except_code),
		.except_extra (except_extra)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// fibonacci LFSR with taps 32 22 2 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_step()};
		end
		return r;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %h actual %h", what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_port(input string name, input int p, input logic [31:0] exp_val,
			input fpu_fmt_t exp_fmt);
		check_value($sformatf("%s rval%0d", name, p), exp_val, rval[p]);
		check_value($sformatf("%s rfmt%0d", name, p), 32'(exp_fmt), 32'(rfmt[p]));
	endtask

	// sel 0 means all four ports
	task automatic check_ports(input string name, input int sel, input logic [31:0] exp_val,
			input fpu_fmt_t exp_fmt);
		for (int p = 1; p <= 4; p++) begin
			if (sel == 0 || sel == p) begin
				check_port(name, p, exp_val, exp_fmt);
			end
		end
	endtask

	task automatic set_raddr(input int sel, input logic [31:0] addr);
		for (int p = 1; p <= 4; p++) begin
			if (sel == 0 || sel == p) begin
				raddr[p] = addr[REG_ADDR_W-1:0];
			end
		end
	endtask

	task automatic init_inputs();
		rst = 1'b1;
		wr1_we = 1'b0;
		wr1_addr = '0;
		wr1_val = '0;
		wr1_fmt = FMT_UNKNOWN;
		wr2_we = 1'b0;
		wr2_addr = '0;
		wr2_val = '0;
		wr2_fmt = FMT_UNKNOWN;
		set_raddr(0, '0);
		fcsr_we = 1'b0;
		fcsr_wdata = '0;
		except_flush = 1'b0;
		except_code = '0;
		except_extra = '0;
		for (int i = 0; i < REG_NUM; i++) begin
			model_val[i] = '0;
			model_fmt[i] = FMT_UNKNOWN;
		end
	endtask

	// inputs change 1 ns after the rising edge and strobes drop by default
	task automatic next_cycle();
		@(posedge clk);
		#1;
		wr1_we = 1'b0;
		wr2_we = 1'b0;
		fcsr_we = 1'b0;
		except_flush = 1'b0;
	endtask

	// writes offered while rst is high must neither show nor stick
	task automatic apply_reset();
		int n;
		for (n = 0; n < RST_CYCLES; n++) begin
			wr1_we = 1'b1;
			wr1_addr = REG_ADDR_W'(2 * n);
			wr1_val = 32'hffff_ffff;
			wr1_fmt = FMT_SINGLE;
			wr2_we = 1'b1;
			wr2_addr = REG_ADDR_W'(2 * n + 1);
			wr2_val = 32'hffff_ffff;
			wr2_fmt = FMT_WORD;
			raddr[1] = wr1_addr;
			raddr[2] = wr1_addr;
			raddr[3] = wr2_addr;
			raddr[4] = wr2_addr;
			fcsr_we = 1'b1;
			fcsr_wdata = '1;
			@(posedge clk);
			#1;
		end
		rst = 1'b0;
		wr1_we = 1'b0;
		wr2_we = 1'b0;
		fcsr_we = 1'b0;
		#2;
		n = 0;
		while (fcsr !== FCSR_RESET && n < RST_TIMEOUT) begin
			@(posedge clk);
			#3;
			n++;
		end
		if (fcsr !== FCSR_RESET) begin
			$display("fcsr did not reach its reset value within %0d cycles", RST_TIMEOUT);
			aborted = 1'b1;
		end
	endtask

	task automatic do_write(input string name, input int port, input logic [31:0] addr,
			input logic [31:0] val, input logic [31:0] fmt);
		next_cycle();
		if (port == 2) begin
			wr2_we = 1'b1;
			wr2_addr = addr[REG_ADDR_W-1:0];
			wr2_val = val;
			wr2_fmt = fpu_fmt_t'(fmt[1:0]);
		end else begin
			wr1_we = 1'b1;
			wr1_addr = addr[REG_ADDR_W-1:0];
			wr1_val = val;
			wr1_fmt = fpu_fmt_t'(fmt[1:0]);
		end
		set_raddr(0, addr);
		#2;
		// bypass shows the write data before the edge
		check_ports(name, 0, val, fpu_fmt_t'(fmt[1:0]));
		model_val[addr[REG_ADDR_W-1:0]] = val;
		model_fmt[addr[REG_ADDR_W-1:0]] = fpu_fmt_t'(fmt[1:0]);
	endtask

	task automatic do_dualwrite(input string name, input logic [31:0] addr,
			input logic [31:0] v1, input logic [31:0] f1,
			input logic [31:0] v2, input logic [31:0] f2);
		next_cycle();
		wr1_we = 1'b1;
		wr1_addr = addr[REG_ADDR_W-1:0];
		wr1_val = v1;
		wr1_fmt = fpu_fmt_t'(f1[1:0]);
		wr2_we = 1'b1;
		wr2_addr = addr[REG_ADDR_W-1:0];
		wr2_val = v2;
		wr2_fmt = fpu_fmt_t'(f2[1:0]);
		set_raddr(0, addr);
		#2;
		// port 2 wins
		check_ports(name, 0, v2, fpu_fmt_t'(f2[1:0]));
		model_val[addr[REG_ADDR_W-1:0]] = v2;
		model_fmt[addr[REG_ADDR_W-1:0]] = fpu_fmt_t'(f2[1:0]);
	endtask

	task automatic read_four(input string name, input int base);
		for (int p = 1; p <= 4; p++) begin
			raddr[p] = REG_ADDR_W'(base + p - 1);
		end
		#2;
		for (int p = 1; p <= 4; p++) begin
			check_port(name, p, model_val[base + p - 1], model_fmt[base + p - 1]);
		end
	endtask

	task automatic run_fill(input string name);
		logic [31:0] rnd;
		// current contents of every entry first
		for (int k = 0; k < REG_NUM; k += 4) begin
			next_cycle();
			read_four(name, k);
		end
		// two entries per cycle with one per write port
		for (int k = 0; k < REG_NUM; k += 2) begin
			next_cycle();
			wr1_we = 1'b1;
			wr1_addr = REG_ADDR_W'(k);
			wr1_val = random_bits(32);
			rnd = random_bits(2);
			wr1_fmt = fpu_fmt_t'(rnd[1:0]);
			wr2_we = 1'b1;
			wr2_addr = REG_ADDR_W'(k + 1);
			wr2_val = random_bits(32);
			rnd = random_bits(2);
			wr2_fmt = fpu_fmt_t'(rnd[1:0]);
			model_val[k] = wr1_val;
			model_fmt[k] = wr1_fmt;
			model_val[k + 1] = wr2_val;
			model_fmt[k + 1] = wr2_fmt;
		end
		for (int k = 0; k < REG_NUM; k += 4) begin
			next_cycle();
			read_four(name, k);
		end
	endtask

	initial begin
		int          fd;
		int          n;
		int          errors_before;
		string       line;
		string       cmd;
		string       name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] e;

		init_inputs();
		lfsr = LFSR_SEED;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		aborted = 1'b0;
		fd = 0;
		apply_reset();
		if (!aborted) begin
			fd = $fopen(TESTS_FILE, "r");
			if (fd == 0) begin
				$display("cannot open the stimulus file %s", TESTS_FILE);
				aborted = 1'b1;
			end
		end
		while (!aborted && !$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			a = '0;
			b = '0;
			c = '0;
			d = '0;
			e = '0;
			n = $sscanf(line, "%s %s %h %h %h %h %h", cmd, name, a, b, c, d, e);
			errors_before = error_count;
			case (cmd)
				"write": do_write(name, int'(a), b, c, d);
				"read": begin
					next_cycle();
					set_raddr(int'(a), b);
					#2;
					check_ports(name, int'(a), c, fpu_fmt_t'(d[1:0]));
				end
				"dualwrite": do_dualwrite(name, a, b, c, d, e);
				"fcsrwrite": begin
					next_cycle();
					fcsr_we = 1'b1;
					fcsr_wdata = a;
					#2;
					check_value(name, a, fcsr);
				end
				"fcsrread": begin
					next_cycle();
					#2;
					check_value(name, a, fcsr);
				end
				"except": begin
					next_cycle();
					except_flush = a[0];
					except_code = b[EXC_CODE_W-1:0];
					except_extra = c[5:0];
					#2;
					check_value(name, d, fcsr);
				end
				"fill": run_fill(name);
				default: begin
					$display("unknown command %s in the stimulus file", cmd);
					error_count++;
				end
			endcase
			if (error_count == errors_before) begin
				pass_count++;
				$display("%-10s %-22s passed", cmd, name);
			end else begin
				fail_count++;
				$display("%-10s %-22s failed", cmd, name);
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (error_count == 0 && !aborted) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* verif/fpu_state_tests.txt */
# command name, then hex fields per command
#   write port addr value fmt | read port(0 = all) addr value fmt | dualwrite addr v1 f1 v2 f2
#   fcsrwrite word | fcsrread word | except flush code extra fcsr | fill (no fields)
# state right after reset
fcsrread reset_fcsr 00000800
fill fill_from_reset
# single writes, bypass in the write cycle, read-back after
write wr1_r3 1 03 3f800000 1
read rd_r3_all 0 03 3f800000 1
write wr2_r17 2 11 c0490fdb 1
read rd_r17_all 0 11 c0490fdb 1
read rd_r3_p4 4 03 3f800000 1
write wr1_r0 1 00 00000007 2
read rd_r0_p1 1 00 00000007 2
read rd_r0_p3 3 00 00000007 2
write wr2_r31 2 1f deadbeef 3
read rd_r31_p2 2 1f deadbeef 3
write wr2_r3_over 2 03 00000000 0
read rd_r3_over 0 03 00000000 0
read rd_r17_kept 0 11 c0490fdb 1
# both ports on one register, port 2 wins
dualwrite dual_r5 05 11111111 1 22222222 2
read rd_r5 0 05 22222222 2
read rd_r5_again 3 05 22222222 2
dualwrite dual_r31 1f aaaaaaaa 3 55555555 1
read rd_r31 0 1f 55555555 1
dualwrite dual_r0 00 0badf00d 2 00000000 0
read rd_r0_cleared 0 00 00000000 0
# FCSR software writes
fcsrwrite fcsr_wr_mode 01000003
fcsrread fcsr_rd_mode 01000003
fcsrread fcsr_rd_mode_held 01000003
# exception cause capture, only bits 17:12 move
except fpe_cause_2a 1 0f 2a 0102a003
fcsrread fpe_cause_2a_held 0102a003
except other_code 1 0e 3f 0102a003
except no_flush 0 0f 3f 0102a003
fcsrread cause_unchanged 0102a003
fcsrwrite fcsr_wr_ones ffffffff
except fpe_cause_05 1 0f 05 fffc5fff
fcsrread fpe_cause_05_held fffc5fff
except fpe_cause_00 1 0f 00 fffc0fff
fcsrread fpe_cause_00_held fffc0fff
fcsrwrite fcsr_wr_zero 00000000
except fpe_cause_3f 1 0f 3f 0003f000
except code_zero 1 00 01 0003f000
fcsrread fpe_cause_3f_held 0003f000
# registers untouched by FCSR traffic
read rd_r5_late 0 05 22222222 2
read rd_r31_late 1 1f 55555555 1
fill fill_random

/* fpu_state.f */
common/fpu_pkg.sv
fpu_regs/fpu_regfile.sv
fpu_regs/fpu_csr.sv
hdl/fpu_state.sv
verif/fpu_state_checker.sv
verif/fpu_state_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fpu_state testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
	-f fpu_state.f \
	--top-module fpu_state_tb \
	-o fpu_state_sim

sim_status=0
sim_out=$(./obj_dir/fpu_state_sim 2>&1) || sim_status=$?
echo "$sim_out"

if ! grep -q "Test OK" <<< "$sim_out"; then
	echo "simulation did not pass (exit status $sim_status)"
	exit 1
fi

exit 0
